/* dtfag.f */
src/tf_pkg.sv
src/tf_addr_gen.sv
src/tf_rom_bank.sv
src/tf_combine.sv
src/tf_data_align.sv
src/tf_lane_mul.sv
src/dtfag_top.sv
test/tb_dtfag.sv

/* src/dtfag_top.sv */
module dtfag_top
    import tf_pkg::*;
#(
    parameter word_t MODULUS = 16'd12289,
    parameter word_t ROOT    = 16'd1331
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  tf_req_t   in_req,
    output logic      in_ready,
    output logic      out_valid,
    output lane_vec_t out_data,
    input  logic      out_ready
);

    logic      advance;
    logic      accept;
    tf_index_t index_q;
    lane_vec_t tf_i;
    lane_vec_t tf_t;
    lane_vec_t tf_j;
    lane_vec_t tf_full;
    lane_vec_t data_dly;

    assign in_ready = advance;

    tf_addr_gen u_addr_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .index_in  (in_req.index),
        .index_out (index_q)
    );

    // one bank per digit, weight 16^DIGIT_POS
    tf_rom_bank #(.MODULUS(MODULUS), .ROOT(ROOT), .DIGIT_POS(0)) u_rom_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .addr    (index_q.i),
        .tf      (tf_i)
    );

    tf_rom_bank #(.MODULUS(MODULUS), .ROOT(ROOT), .DIGIT_POS(1)) u_rom_t (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .addr    (index_q.t),
        .tf      (tf_t)
    );

    tf_rom_bank #(.MODULUS(MODULUS), .ROOT(ROOT), .DIGIT_POS(2)) u_rom_j (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .addr    (index_q.j),
        .tf      (tf_j)
    );

    tf_combine #(.MODULUS(MODULUS)) u_combine (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .tf0     (tf_i),
        .tf1     (tf_t),
        .tf2     (tf_j),
        .tf      (tf_full)
    );

    tf_data_align u_data_align (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .data_in   (in_req.data),
        .out_ready (out_ready),
        .advance   (advance),
        .accept    (accept),
        .data_out  (data_dly),
        .out_valid (out_valid)
    );

    tf_lane_mul #(.MODULUS(MODULUS)) u_lane_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .data    (data_dly),
        .tf      (tf_full),
        .result  (out_data)
    );

endmodule

/* src/tf_addr_gen.sv */
module tf_addr_gen
    import tf_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      accept,
    input  tf_index_t index_in,
    output tf_index_t index_out
);

    tf_index_t index_q;

    // address stage in front of the three ROM banks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q <= '0;
        end else if (accept) begin
            index_q <= index_in;
        end
    end

    assign index_out = index_q;

endmodule

/* src/tf_combine.sv */
module tf_combine
    import tf_pkg::*;
#(
    parameter word_t MODULUS = 16'd12289
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      advance,
    input  lane_vec_t tf0,
    input  lane_vec_t tf1,
    input  lane_vec_t tf2,
    output lane_vec_t tf
);

    lane_vec_t prod01_q;
    lane_vec_t tf2_q;
    lane_vec_t tf_q;

    // stage 1: low two digits, high digit rides along
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod01_q <= '0;
            tf2_q    <= '0;
        end else if (advance) begin
            for (int b = 0; b < LANES; b++) begin
                prod01_q[b] <= mod_mul(tf0[b], tf1[b], MODULUS);
            end
            tf2_q <= tf2;
        end
    end

    // stage 2: full twiddle per lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tf_q <= '0;
        end else if (advance) begin
            for (int b = 0; b < LANES; b++) begin
                tf_q[b] <= mod_mul(prod01_q[b], tf2_q[b], MODULUS);
            end
        end
    end

    assign tf = tf_q;

endmodule

/* src/tf_data_align.sv */
module tf_data_align
    import tf_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  lane_vec_t data_in,
    input  logic      out_ready,
    output logic      advance,
    output logic      accept,
    output lane_vec_t data_out,
    output logic      out_valid
);

    localparam int VALID_DEPTH = 5;
    localparam int DATA_DEPTH  = 4;

    logic [VALID_DEPTH-1:0] valid_q;
    lane_vec_t              data_q [DATA_DEPTH];

    // whole pipeline moves unless a result is waiting on out_ready
    assign advance   = !valid_q[VALID_DEPTH-1] || out_ready;
    assign accept    = in_valid && advance;
    assign out_valid = valid_q[VALID_DEPTH-1];
    assign data_out  = data_q[DATA_DEPTH-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            for (int s = 0; s < DATA_DEPTH; s++) begin
                data_q[s] <= '0;
            end
        end else if (advance) begin
            valid_q <= {valid_q[VALID_DEPTH-2:0], accept};
            // data meets its twiddle at the lane multiplier
            data_q[0] <= data_in;
            for (int s = 1; s < DATA_DEPTH; s++) begin
                data_q[s] <= data_q[s-1];
            end
        end
    end

endmodule

/* src/tf_lane_mul.sv */
module tf_lane_mul
    import tf_pkg::*;
#(
    parameter word_t MODULUS = 16'd12289
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      advance,
    input  lane_vec_t data,
    input  lane_vec_t tf,
    output lane_vec_t result
);

    lane_vec_t result_q;

    // held while stalled, so out_data stays stable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (advance) begin
            for (int b = 0; b < LANES; b++) begin
                result_q[b] <= mod_mul(data[b], tf[b], MODULUS);
            end
        end
    end

    assign result = result_q;

endmodule

/* src/tf_pkg.sv */
package tf_pkg;

    localparam int D_WIDTH    = 16;
    localparam int LANES      = 4;
    localparam int RADIX_BITS = 4;
    localparam int ROM_DEPTH  = 16;
    localparam int EXP_BITS   = 12;

    typedef logic [RADIX_BITS-1:0] digit_t;
    typedef logic [D_WIDTH-1:0]    word_t;
    typedef word_t [LANES-1:0]     lane_vec_t;

    // k = j*256 + t*16 + i
    typedef struct packed {
        digit_t j;
        digit_t t;
        digit_t i;
    } tf_index_t;

    typedef struct packed {
        tf_index_t index;
        lane_vec_t data;
    } tf_req_t;

    function automatic word_t mod_mul(word_t a, word_t b, word_t modulus);
        logic [2*D_WIDTH-1:0] prod;
        prod = a * b;
        return word_t'(prod % modulus);
    endfunction

    // square and multiply over the exponent bits
    function automatic word_t mod_pow(word_t base, logic [EXP_BITS-1:0] exp,
                                      word_t modulus);
        word_t result;
        word_t sq;
        result = word_t'(1 % modulus);
        sq     = word_t'(base % modulus);
        for (int n = 0; n < EXP_BITS; n++) begin
            if (exp[n]) begin
                result = mod_mul(result, sq, modulus);
            end
            sq = mod_mul(sq, sq, modulus);
        end
        return result;
    endfunction

endpackage

/* src/tf_rom_bank.sv */
module tf_rom_bank
    import tf_pkg::*;
#(
    parameter word_t MODULUS   = 16'd12289,
    parameter word_t ROOT      = 16'd1331,
    parameter int    DIGIT_POS = 0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      advance,
    input  digit_t    addr,
    output lane_vec_t tf
);

    typedef logic [ROM_DEPTH-1:0][D_WIDTH-1:0] table_t;

    // entry d of lane b holds ROOT^(b*d*16^DIGIT_POS mod 4096)
    function automatic table_t build_table(int lane);
        table_t tbl;
        int     e;
        for (int d = 0; d < ROM_DEPTH; d++) begin
            e      = (lane * d * (1 << (RADIX_BITS * DIGIT_POS))) % (1 << EXP_BITS);
            tbl[d] = mod_pow(ROOT, EXP_BITS'(e), MODULUS);
        end
        return tbl;
    endfunction

    lane_vec_t tf_q;

    for (genvar b = 0; b < LANES; b++) begin : g_lane
        localparam table_t TABLE = build_table(b);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                tf_q[b] <= '0;
            end else if (advance) begin
                tf_q[b] <= TABLE[addr];
            end
        end
    end

    assign tf = tf_q;

endmodule

/* test/dtfag_patterns.hex */
// columns: j t i | data lane 0 1 2 3 | expected lane 0 1 2 3
// all words in hex, data words below the modulus 12289
0 0 0 0001 0002 0003 0004 0001 0002 0003 0004
0 0 0 3000 2abc 1234 0fed 3000 2abc 1234 0fed
0 0 1 0101 0001 0001 0001 0101 0533 0799 1fa9
0 0 2 0202 0001 0001 0001 0202 0799 283e 18b0
0 0 4 0303 0002 0002 0002 0303 207b 1a90 189c
0 0 8 0404 0001 0001 0001 0404 0d48 2094 149d
0 1 0 0505 3000 3000 3000 0505 0f6d 008c 0091
0 2 0 0606 0001 0001 0001 0606 2f75 1c8f 2220
0 4 0 0707 0003 0003 0003 0707 25ac 14ab 233a
0 8 0 0808 0001 0001 0001 0808 16e4 1026 0e25
1 0 0 0909 0002 0002 0002 0909 204c 106b 2a5d
2 0 0 0a0a 0001 0001 0001 0a0a 2036 05c7 141a
4 0 0 0b0b 3000 3000 3000 0b0b 2a3a 0001 05c7
8 0 0 0c0c 0005 0007 0009 0c0c 2ffc 0007 2ff8
c 0 0 0d0d 0001 0001 0001 0d0d 2a3a 3000 05c7
f f f 0e0e 0001 0001 0001 0e0e 1f20 0fd2 2dff
f f f 0f0f 0533 0799 1fa9 0f0f 0001 0001 0001
0 1 1 1010 0001 0001 0001 1010 0df5 286b 11a7
8 0 1 1111 0001 0001 0001 1111 2ace 0799 1058
8 1 0 1212 0002 0002 0002 1212 1eda 2ee9 0122
8 1 1 1313 0001 0001 0001 1313 220c 286b 1e5a
0 0 0 2222 0bad 1ace 2d00 2222 0bad 1ace 2d00
0 0 1 1414 1f20 0fd2 2dff 1414 0001 0001 0001
8 0 0 1515 3000 3000 3000 1515 0001 3000 0001
c 0 0 1616 05c7 3000 05c7 1616 0001 0001 3000
0 0 0 0000 0000 0000 0000 0000 0000 0000 0000

/* test/tb_dtfag.sv */
module tb_dtfag
    import tf_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD       = 100;
    localparam int    RESET_CYCLES     = 5;
    localparam int    NUM_PATTERNS     = 26;
    localparam int    PATTERN_WORDS    = 11;
    localparam int    LATENCY          = 5;
    localparam int    FULL_RATE_CYCLES = 16;
    localparam int    TIMEOUT_CYCLES   = NUM_PATTERNS * 20 + 50;
    localparam word_t TB_MODULUS       = 16'd12289;
    localparam word_t TB_ROOT          = 16'd1331;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    tf_req_t   in_req;
    logic      in_ready;
    logic      out_valid;
    lane_vec_t out_data;
    logic      out_ready;

    logic [15:0] pattern_mem [NUM_PATTERNS*PATTERN_WORDS];
    int          accept_cycle [NUM_PATTERNS];
    int          cycle;
    int          sent_count;
    int          out_count;
    logic        stall_seen;
    logic        hold_valid;
    lane_vec_t   hold_data;
    logic [31:0] rng_state;

    dtfag_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_failure(string what);
        $display("%s (time %0t)", what, $time);
        stop_with_failure();
    endtask

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    function automatic tf_req_t request_at(int p);
        tf_req_t req;
        int      base;
        base        = p * PATTERN_WORDS;
        req.index.j = pattern_mem[base][3:0];
        req.index.t = pattern_mem[base+1][3:0];
        req.index.i = pattern_mem[base+2][3:0];
        for (int b = 0; b < LANES; b++) begin
            req.data[b] = pattern_mem[base+3+b];
        end
        return req;
    endfunction

    function automatic word_t expected_word(int p, int b);
        return pattern_mem[p*PATTERN_WORDS+7+b];
    endfunction

    // twiddle for lane b is ROOT^(b*k mod 4096)
    task automatic verify_pattern_file();
        int    base;
        int    k;
        word_t tw;
        word_t ref_word;
        for (int p = 0; p < NUM_PATTERNS; p++) begin
            base = p * PATTERN_WORDS;
            for (int w = 0; w < PATTERN_WORDS; w++) begin
                if ($isunknown(pattern_mem[base+w])) begin
                    report_failure("pattern file is shorter than expected");
                end
            end
            k = pattern_mem[base] * 256 + pattern_mem[base+1] * 16 + pattern_mem[base+2];
            for (int b = 0; b < LANES; b++) begin
                if (pattern_mem[base+3+b] >= TB_MODULUS) begin
                    report_failure("pattern file holds a data word not below the modulus");
                end
                tw       = mod_pow(TB_ROOT, EXP_BITS'((b * k) % (1 << EXP_BITS)), TB_MODULUS);
                ref_word = mod_mul(pattern_mem[base+3+b], tw, TB_MODULUS);
                check_value($sformatf("pattern %0d expected lane %0d", p, b),
                            expected_word(p, b), ref_word);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // out_ready held high first and random afterwards
    always @(posedge clk) begin
        if (rst_n) begin
            if (cycle < RESET_CYCLES + FULL_RATE_CYCLES) begin
                out_ready <= 1'b1;
            end else begin
                rng_state = xorshift32(rng_state);
                out_ready <= rng_state[0];
            end
        end
    end

    // output monitor and scoreboard
    always @(posedge clk) begin
        if (rst_n) begin
            if (!out_valid && !in_ready) begin
                report_failure("in_ready is low while out_valid is low");
            end
            if (hold_valid) begin
                if (!out_valid) begin
                    report_failure("out_valid dropped before its result was taken");
                end
                check_value("out_data while stalled", out_data, hold_data);
            end
            check_value("in_ready", in_ready, !(out_valid && !out_ready));
            if (out_valid && out_ready) begin
                if (out_count >= NUM_PATTERNS) begin
                    report_failure("output transfer with no pattern left");
                end
                // lane 0 twiddle is always 1
                check_value("out_data[0] against its input", out_data[0],
                            pattern_mem[out_count*PATTERN_WORDS+3]);
                for (int b = 0; b < LANES; b++) begin
                    check_value($sformatf("out_data[%0d]", b), out_data[b],
                                expected_word(out_count, b));
                end
                if (!stall_seen) begin
                    check_value("latency", cycle - accept_cycle[out_count], LATENCY);
                end
                out_count++;
            end
            hold_valid = out_valid && !out_ready;
            hold_data  = out_data;
            if (hold_valid) begin
                stall_seen = 1'b1;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        report_failure("timeout, not all patterns came out in time");
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b1;
        rng_state  = 32'h900c;
        cycle      = 0;
        sent_count = 0;
        out_count  = 0;
        stall_seen = 1'b0;
        hold_valid = 1'b0;
        hold_data  = '0;
        $readmemh("test/dtfag_patterns.hex", pattern_mem);
        verify_pattern_file();

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_value("out_valid", out_valid, 1'b0);
            check_value("in_ready", in_ready, 1'b1);
        end
        rst_n    <= 1'b1;
        in_valid <= 1'b1;
        in_req   <= request_at(0);

        // next request only after a transfer
        while (sent_count < NUM_PATTERNS) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                accept_cycle[sent_count] = cycle;
                sent_count++;
                if (sent_count < NUM_PATTERNS) begin
                    in_req <= request_at(sent_count);
                end else begin
                    in_valid <= 1'b0;
                    in_req   <= '0;
                end
            end
        end

        while (out_count < NUM_PATTERNS) begin
            @(posedge clk);
        end
        repeat (2 * LATENCY) @(posedge clk);

        if (!out_valid) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure("pipeline did not drain after the last pattern");
        end
    end

endmodule
